/* common/fcl_params.svh */
// only the two extended DMA commands are decoded; timing values are in clk cycles
`ifndef FCL_PARAMS_SVH
`define FCL_PARAMS_SVH

// ata command codes
`define FCL_COMMAND_DMA_READ_EX     8'h25
`define FCL_COMMAND_DMA_WRITE_EX    8'h35

// software reset bit in the h2d control byte
`define FCL_CONTROL_SRST_BIT        2

// power-up delay before diagnostics
`define FCL_SLEEP_CYCLES            16'd1000

// 512-byte sectors
`define FCL_DWORDS_PER_SECTOR       128

// fixed sizes reported for the short-circuited fifos
`define FCL_OF_SIZE                 24'd2048
`define FCL_IF_SIZE                 24'd256

// error register values
`define FCL_ERROR_ABORT             8'h04
`define FCL_ERROR_DIAG_OK           8'h01

`endif

/* common/fcl_pkg.sv */
// state codes are fixed 4-bit values because cl_state leaves the design raw for debug
package fcl_pkg;

    // command-layer sequencer states
    typedef enum logic [3:0] {
        sleep_start      = 4'h0,
        send_diagnostics = 4'h1,
        idle             = 4'h2,
        dma_ready        = 4'h3,
        read_data        = 4'h4,
        send_data        = 4'h5,
        read_in_progress = 4'h6,
        send_status      = 4'h7
    } fcl_state_t;

    // ata status bits, bsy is the msb
    typedef struct packed {
        logic bsy;
        logic drdy;
        logic df;
        logic dsc;
        logic drq;
        logic corr;
        logic idx;
        logic err;
    } ata_status_flags_t;

    // status byte, built by flag and sent to the host raw
    typedef union packed {
        logic [7:0]        raw;
        ata_status_flags_t flags;
    } ata_status_t;

endpackage

/* rtl/fcl_sequencer.sv */
// every frame waits for transport_layer_ready; soft reset overrides any command in flight
`include "fcl_params.svh"

module fcl_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  logic                h2d_reg_stb,
    input  logic                h2d_cmd_bit,
    input  logic [7:0]          h2d_command,
    input  logic [7:0]          h2d_control,
    input  logic                h2d_data_stb,
    input  logic                transport_layer_ready,
    input  logic                sleep_done,
    input  logic                sectors_left,
    output fcl_pkg::fcl_state_t state,
    output logic                send_reg_stb,
    output logic                send_dma_act_stb,
    output logic                send_data_stb,
    output logic                sleep_start,
    output logic                sector_clear,
    output logic                accept_cmd,
    output logic                cmd_abort,
    output logic                complete
);

    logic soft_reset;
    logic known_cmd;

    assign soft_reset = h2d_control[`FCL_CONTROL_SRST_BIT];

    // timer restarts on the same edge the state falls back
    assign sleep_start = soft_reset;

    // command taken on the edge of the register strobe
    assign accept_cmd   = (state == fcl_pkg::idle) && h2d_reg_stb && h2d_cmd_bit
                          && !soft_reset;
    assign sector_clear = accept_cmd;

    assign known_cmd = (h2d_command == `FCL_COMMAND_DMA_READ_EX)
                       || (h2d_command == `FCL_COMMAND_DMA_WRITE_EX);

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= fcl_pkg::sleep_start;
            send_reg_stb     <= 1'b0;
            send_dma_act_stb <= 1'b0;
            send_data_stb    <= 1'b0;
            cmd_abort        <= 1'b0;
            complete         <= 1'b0;
        end else begin
            // strobes default low
            send_reg_stb     <= 1'b0;
            send_dma_act_stb <= 1'b0;
            send_data_stb    <= 1'b0;
            complete         <= 1'b0;

            if (soft_reset) begin
                state <= fcl_pkg::sleep_start;
            end else begin
                case (state)
                    fcl_pkg::sleep_start: begin
                        if (sleep_done) begin
                            state <= fcl_pkg::send_diagnostics;
                        end
                    end
                    fcl_pkg::send_diagnostics: begin
                        if (transport_layer_ready) begin
                            send_reg_stb <= 1'b1;
                            state        <= fcl_pkg::idle;
                        end
                    end
                    fcl_pkg::idle: begin
                        if (accept_cmd) begin
                            cmd_abort <= !known_cmd;
                            case (h2d_command)
                                `FCL_COMMAND_DMA_READ_EX:  state <= fcl_pkg::send_data;
                                `FCL_COMMAND_DMA_WRITE_EX: state <= fcl_pkg::dma_ready;
                                // unknown command answered with abort status
                                default:                   state <= fcl_pkg::send_status;
                            endcase
                        end
                    end
                    fcl_pkg::dma_ready: begin
                        // one activate per sector
                        if (transport_layer_ready) begin
                            send_dma_act_stb <= 1'b1;
                            state            <= fcl_pkg::read_data;
                        end
                    end
                    fcl_pkg::read_data: begin
                        if (h2d_data_stb) begin
                            state <= sectors_left ? fcl_pkg::dma_ready : fcl_pkg::send_status;
                        end
                    end
                    fcl_pkg::send_data: begin
                        if (transport_layer_ready) begin
                            send_data_stb <= 1'b1;
                            state         <= fcl_pkg::read_in_progress;
                        end
                    end
                    fcl_pkg::read_in_progress: begin
                        // transport drops ready while the data frame goes out
                        if (!transport_layer_ready) begin
                            state <= fcl_pkg::send_status;
                        end
                    end
                    fcl_pkg::send_status: begin
                        if (transport_layer_ready) begin
                            send_reg_stb <= 1'b1;
                            complete     <= 1'b1;
                            state        <= fcl_pkg::idle;
                        end
                    end
                    default: begin
                        state <= fcl_pkg::sleep_start;
                    end
                endcase
            end
        end
    end

    // transport layer takes one frame request at a time
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({send_reg_stb, send_dma_act_stb, send_data_stb}));

    assert property (@(posedge clk) disable iff (rst)
        state inside {fcl_pkg::sleep_start, fcl_pkg::send_diagnostics, fcl_pkg::idle,
                      fcl_pkg::dma_ready, fcl_pkg::read_data, fcl_pkg::send_data,
                      fcl_pkg::read_in_progress, fcl_pkg::send_status});

endmodule

/* rtl/fcl_counters.sv */
// a sector target of zero is treated as no sectors, not as 65536
`include "fcl_params.svh"

module fcl_counters (
    input  logic        clk,
    input  logic        rst,
    input  logic        sleep_start,
    input  logic        sector_clear,
    input  logic        sector_done,
    input  logic [15:0] sector_target,
    output logic        sleep_done,
    output logic        sectors_left
);

    logic [15:0] sleep_count;
    logic [15:0] sector_count;
    logic [15:0] sector_goal;

    // power-up timer, saturates at the delay
    always_ff @(posedge clk) begin
        if (rst) begin
            sleep_count <= 16'd0;
        end else if (sleep_start) begin
            sleep_count <= 16'd0;
        end else if (sleep_count < `FCL_SLEEP_CYCLES) begin
            sleep_count <= sleep_count + 16'd1;
        end
    end

    assign sleep_done = (sleep_count == `FCL_SLEEP_CYCLES);

    // received sectors of the current write
    always_ff @(posedge clk) begin
        if (rst) begin
            sector_count <= 16'd0;
            sector_goal  <= 16'd0;
        end else if (sector_clear) begin
            sector_count <= 16'd0;
            sector_goal  <= sector_target;
        end else if (sector_done) begin
            sector_count <= sector_count + 16'd1;
        end
    end

    // count plus one, so the frame of the last sector ends the transfer
    assign sectors_left = ({1'b0, sector_count} + 17'd1) < {1'b0, sector_goal};

    // host never sends more sectors than it asked for
    assert property (@(posedge clk) disable iff (rst)
        sector_done |-> (sector_count < sector_goal));

endmodule

/* rtl/fcl_data_port.sv */
// ping-pong fifos are short-circuited; ready and size outputs are constants
`include "fcl_params.svh"

module fcl_data_port (
    input  logic        clk,
    input  logic        rst,
    input  logic        cl_of_strobe,
    input  logic [31:0] cl_of_data,
    input  logic [1:0]  cl_of_activate,
    input  logic        cl_if_strobe,
    input  logic [31:0] hd_data_to_host,
    output logic        hd_read_from_host,
    output logic [31:0] hd_data_from_host,
    output logic [1:0]  cl_of_ready,
    output logic [23:0] cl_of_size,
    output logic        hd_write_to_host,
    output logic [31:0] cl_if_data,
    output logic        cl_if_ready,
    output logic [23:0] cl_if_size,
    output logic        sector_done
);

    logic       of_accept;
    logic [6:0] dword_count;
    logic       last_dword;

    // either half of the output fifo may be active
    assign of_accept  = cl_of_strobe && (|cl_of_activate);
    assign last_dword = (dword_count == 7'(`FCL_DWORDS_PER_SECTOR - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            hd_read_from_host <= 1'b0;
            sector_done       <= 1'b0;
            dword_count       <= 7'd0;
        end else begin
            hd_read_from_host <= of_accept;
            sector_done       <= of_accept && last_dword;
            if (of_accept) begin
                dword_count <= last_dword ? 7'd0 : dword_count + 7'd1;
            end
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (of_accept) begin
            hd_data_from_host <= cl_of_data;
        end
    end

    assign cl_of_ready = 2'b11;
    assign cl_of_size  = `FCL_OF_SIZE;

    // read side passes straight through
    assign hd_write_to_host = cl_if_strobe;
    assign cl_if_data       = hd_data_to_host;
    assign cl_if_ready      = 1'b1;
    assign cl_if_size       = `FCL_IF_SIZE;

endmodule

/* rtl/fcl_register_file.sv */
// device register is fixed at zero; soft reset leaves the last status in place
`include "fcl_params.svh"

module fcl_register_file (
    input  logic        clk,
    input  logic        rst,
    input  logic        accept_cmd,
    input  logic        cmd_abort,
    input  logic        complete,
    input  logic [47:0] h2d_lba,
    input  logic [15:0] h2d_sector_count,
    output logic [7:0]  d2h_status,
    output logic [7:0]  d2h_error,
    output logic [47:0] d2h_lba,
    output logic [15:0] d2h_sector_count,
    output logic [7:0]  d2h_device,
    output logic        d2h_interrupt
);

    fcl_pkg::ata_status_t status_q;
    fcl_pkg::ata_status_t ready_status;
    fcl_pkg::ata_status_t abort_status;

    // drive ready and seek complete, plus err on abort
    always_comb begin
        ready_status            = '0;
        ready_status.flags.drdy = 1'b1;
        ready_status.flags.dsc  = 1'b1;
        abort_status            = ready_status;
        abort_status.flags.err  = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q         <= ready_status;
            d2h_error        <= `FCL_ERROR_DIAG_OK;
            d2h_lba          <= 48'd1;
            d2h_sector_count <= 16'd1;
            d2h_interrupt    <= 1'b0;
        end else if (accept_cmd) begin
            d2h_lba          <= h2d_lba;
            d2h_sector_count <= h2d_sector_count;
            d2h_interrupt    <= 1'b0;
        end else if (complete) begin
            d2h_interrupt <= 1'b1;
            if (cmd_abort) begin
                status_q  <= abort_status;
                d2h_error <= `FCL_ERROR_ABORT;
            end else begin
                status_q  <= ready_status;
                d2h_error <= 8'h00;
            end
        end
    end

    assign d2h_status = status_q.raw;
    assign d2h_device = 8'h00;

endmodule

/* rtl/faux_hd_command_layer.sv */
// simulated drive: no PIO, dev-bits, notification, port multiplier or error recovery
module faux_hd_command_layer (
    input  logic                clk,
    input  logic                rst,
    output logic                command_layer_ready,
    output logic                command_layer_busy,
    output logic                hd_read_from_host,
    output logic [31:0]         hd_data_from_host,
    output logic                hd_write_to_host,
    input  logic [31:0]         hd_data_to_host,
    input  logic                transport_layer_ready,
    output logic                send_reg_stb,
    output logic                send_dma_act_stb,
    output logic                send_data_stb,
    output logic                send_pio_stb,
    output logic                send_dev_bits_stb,
    input  logic                h2d_reg_stb,
    input  logic                h2d_data_stb,
    output logic [15:0]         pio_transfer_count,
    output logic                pio_direction,
    output logic [7:0]          pio_e_status,
    input  logic [7:0]          h2d_command,
    input  logic                h2d_cmd_bit,
    input  logic [7:0]          h2d_control,
    input  logic [47:0]         h2d_lba,
    input  logic [15:0]         h2d_sector_count,
    output logic                d2h_interrupt,
    output logic                d2h_notification,
    output logic [7:0]          d2h_status,
    output logic [7:0]          d2h_error,
    output logic [3:0]          d2h_port_mult,
    output logic [7:0]          d2h_device,
    output logic [47:0]         d2h_lba,
    output logic [15:0]         d2h_sector_count,
    input  logic                cl_if_strobe,
    output logic [31:0]         cl_if_data,
    output logic                cl_if_ready,
    output logic [23:0]         cl_if_size,
    input  logic                cl_of_strobe,
    input  logic [31:0]         cl_of_data,
    output logic [1:0]          cl_of_ready,
    input  logic [1:0]          cl_of_activate,
    output logic [23:0]         cl_of_size,
    output fcl_pkg::fcl_state_t cl_state
);

    logic sleep_start;
    logic sleep_done;
    logic sector_clear;
    logic sectors_left;
    logic sector_done;
    logic accept_cmd;
    logic cmd_abort;
    logic complete;

    // only idle takes new commands
    assign command_layer_ready = (cl_state == fcl_pkg::idle);
    assign command_layer_busy  = !command_layer_ready;

    // unsupported features tied off
    assign send_pio_stb       = 1'b0;
    assign send_dev_bits_stb  = 1'b0;
    assign pio_transfer_count = 16'd0;
    assign pio_direction      = 1'b0;
    assign pio_e_status       = 8'h00;
    assign d2h_notification   = 1'b0;
    assign d2h_port_mult      = 4'h0;

    fcl_sequencer fcl_sequencer_inst (
        .clk                   (clk),
        .rst                   (rst),
        .h2d_reg_stb           (h2d_reg_stb),
        .h2d_cmd_bit           (h2d_cmd_bit),
        .h2d_command           (h2d_command),
        .h2d_control           (h2d_control),
        .h2d_data_stb          (h2d_data_stb),
        .transport_layer_ready (transport_layer_ready),
        .sleep_done            (sleep_done),
        .sectors_left          (sectors_left),
        .state                 (cl_state),
        .send_reg_stb          (send_reg_stb),
        .send_dma_act_stb      (send_dma_act_stb),
        .send_data_stb         (send_data_stb),
        .sleep_start           (sleep_start),
        .sector_clear          (sector_clear),
        .accept_cmd            (accept_cmd),
        .cmd_abort             (cmd_abort),
        .complete              (complete)
    );

    fcl_counters fcl_counters_inst (
        .clk           (clk),
        .rst           (rst),
        .sleep_start   (sleep_start),
        .sector_clear  (sector_clear),
        .sector_done   (sector_done),
        .sector_target (h2d_sector_count),
        .sleep_done    (sleep_done),
        .sectors_left  (sectors_left)
    );

    fcl_data_port fcl_data_port_inst (
        .clk               (clk),
        .rst               (rst),
        .cl_of_strobe      (cl_of_strobe),
        .cl_of_data        (cl_of_data),
        .cl_of_activate    (cl_of_activate),
        .cl_if_strobe      (cl_if_strobe),
        .hd_data_to_host   (hd_data_to_host),
        .hd_read_from_host (hd_read_from_host),
        .hd_data_from_host (hd_data_from_host),
        .cl_of_ready       (cl_of_ready),
        .cl_of_size        (cl_of_size),
        .hd_write_to_host  (hd_write_to_host),
        .cl_if_data        (cl_if_data),
        .cl_if_ready       (cl_if_ready),
        .cl_if_size        (cl_if_size),
        .sector_done       (sector_done)
    );

    fcl_register_file fcl_register_file_inst (
        .clk              (clk),
        .rst              (rst),
        .accept_cmd       (accept_cmd),
        .cmd_abort        (cmd_abort),
        .complete         (complete),
        .h2d_lba          (h2d_lba),
        .h2d_sector_count (h2d_sector_count),
        .d2h_status       (d2h_status),
        .d2h_error        (d2h_error),
        .d2h_lba          (d2h_lba),
        .d2h_sector_count (d2h_sector_count),
        .d2h_device       (d2h_device),
        .d2h_interrupt    (d2h_interrupt)
    );

endmodule

/* sim/clk_gen.sv */
// free-running testbench clock of period 20, reset held for the first three rising edges
module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // synchronous reset, released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* sim/tb_faux_hd_command_layer.sv */
// transport model keeps ready high except during reads; write rows need a sector count of one or more
`include "fcl_params.svh"

module tb_faux_hd_command_layer;

    localparam int NUM_ROWS = 5;

    logic clk, rst;
    logic command_layer_ready, command_layer_busy, hd_read_from_host, hd_write_to_host;
    logic send_reg_stb, send_dma_act_stb, send_data_stb, send_pio_stb, send_dev_bits_stb;
    logic pio_direction, d2h_interrupt, d2h_notification, cl_if_ready;
    logic [31:0] hd_data_from_host, cl_if_data, hd_data_to_host, cl_of_data;
    logic [15:0] pio_transfer_count, d2h_sector_count, h2d_sector_count;
    logic [7:0] pio_e_status, d2h_status, d2h_error, d2h_device, h2d_command, h2d_control;
    logic [3:0] d2h_port_mult;
    logic [47:0] d2h_lba, h2d_lba;
    logic [23:0] cl_if_size, cl_of_size;
    logic [1:0] cl_of_ready, cl_of_activate;
    logic transport_layer_ready, h2d_reg_stb, h2d_data_stb, h2d_cmd_bit;
    logic cl_if_strobe, cl_of_strobe;
    fcl_pkg::fcl_state_t cl_state;

    // columns: command, lba, sector count, soft reset first, expected status, expected error
    logic [7:0]  row_cmd    [NUM_ROWS] = '{`FCL_COMMAND_DMA_WRITE_EX, `FCL_COMMAND_DMA_READ_EX,
                                           8'hec, `FCL_COMMAND_DMA_WRITE_EX,
                                           `FCL_COMMAND_DMA_WRITE_EX};
    logic [47:0] row_lba    [NUM_ROWS] = '{48'h0000_1234_5678, 48'h0000_0000_0800,
                                           48'h0000_0000_0010, 48'habcd_0000_0042,
                                           48'h7fff_ffff_fff0};
    logic [15:0] row_count  [NUM_ROWS] = '{16'd2, 16'd1, 16'd1, 16'd1, 16'd3};
    logic        row_srst   [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
    logic [7:0]  row_status [NUM_ROWS] = '{8'h50, 8'h50, 8'h51, 8'h50, 8'h50};
    logic [7:0]  row_error  [NUM_ROWS] = '{8'h00, 8'h00, `FCL_ERROR_ABORT, 8'h00, 8'h00};

    int error_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int reg_count = 0;
    int dma_count = 0;
    int data_count = 0;
    integer seed = 10;
    logic [31:0] write_q [$];

    clk_gen clk_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    faux_hd_command_layer faux_hd_command_layer_inst (.*);

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // strobe counting and write data scoreboard, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (send_reg_stb) reg_count++;
            if (send_dma_act_stb) dma_count++;
            if (send_data_stb) data_count++;
            if (hd_read_from_host) begin
                if (write_q.size() == 0) begin
                    error_count++;
                    $display("disk port took a write dword at %0t that was never sent", $time);
                end else begin
                    check_value("hd_data_from_host", write_q.pop_front(), hd_data_from_host);
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += `FCL_SLEEP_CYCLES + 300 * row_count[r];
        end
        repeat (limit) @(posedge clk);
        $display("run stopped after %0d clock cycles, the DUT stopped responding", limit);
        $display("ERRORS FOUND");
        $finish;
    end

    function automatic fcl_pkg::fcl_state_t state_after_command(input logic [7:0] cmd);
        if (cmd == `FCL_COMMAND_DMA_WRITE_EX) begin
            return fcl_pkg::dma_ready;
        end else if (cmd == `FCL_COMMAND_DMA_READ_EX) begin
            return fcl_pkg::send_data;
        end
        return fcl_pkg::send_status;
    endfunction

    task automatic wait_ready();
        do @(negedge clk); while (!command_layer_ready);
    endtask

    task automatic report_test(input string label, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s passed", label);
        end else begin
            tests_failed++;
            $display("%s failed with %0d errors", label, error_count - errors_before);
        end
    endtask

    task automatic power_up_test();
        int errors_before;
        errors_before = error_count;
        check_value("command_layer_ready", 0, command_layer_ready);
        check_value("command_layer_busy", 1, command_layer_busy);
        check_value("send strobes", 0, {send_reg_stb, send_dma_act_stb, send_data_stb});
        check_value("pio and dev-bits strobes", 0, {send_pio_stb, send_dev_bits_stb});
        check_value("pio_transfer_count", 0, pio_transfer_count);
        check_value("pio_direction", 0, pio_direction);
        check_value("pio_e_status", 0, pio_e_status);
        check_value("d2h_notification", 0, d2h_notification);
        check_value("d2h_port_mult", 0, d2h_port_mult);
        check_value("d2h_device", 0, d2h_device);
        check_value("d2h_lba", 1, d2h_lba);
        check_value("d2h_sector_count", 1, d2h_sector_count);
        check_value("d2h_interrupt", 0, d2h_interrupt);
        check_value("hd_read_from_host", 0, hd_read_from_host);
        // short-circuited fifos report fixed ready and size
        check_value("cl_of_ready", 2'b11, cl_of_ready);
        check_value("cl_of_size", `FCL_OF_SIZE, cl_of_size);
        check_value("cl_if_ready", 1, cl_if_ready);
        check_value("cl_if_size", `FCL_IF_SIZE, cl_if_size);
        check_value("cl_state", fcl_pkg::sleep_start, cl_state);
        wait_ready();
        @(posedge clk);
        check_value("send_reg_stb pulses", 1, reg_count);
        check_value("send_dma_act_stb pulses", 0, dma_count);
        check_value("send_data_stb pulses", 0, data_count);
        @(negedge clk);
        check_value("d2h_status", 8'h50, d2h_status);
        check_value("d2h_error", `FCL_ERROR_DIAG_OK, d2h_error);
        check_value("command_layer_busy", 0, command_layer_busy);
        report_test("test power-up", errors_before);
    endtask

    // pulse the srst bit and wait for a fresh diagnostics frame
    task automatic soft_reset();
        int reg0;
        @(posedge clk);
        reg0 = reg_count;
        h2d_control <= 8'(1 << `FCL_CONTROL_SRST_BIT);
        @(posedge clk);
        h2d_control <= 8'h00;
        @(negedge clk);
        check_value("command_layer_ready", 0, command_layer_ready);
        wait_ready();
        @(posedge clk);
        check_value("diagnostics send_reg_stb pulses", reg0 + 1, reg_count);
    endtask

    task automatic write_sectors(input int sectors);
        logic [31:0] word;
        for (int s = 0; s < sectors; s++) begin
            do @(negedge clk); while (!send_dma_act_stb);
            for (int i = 0; i < `FCL_DWORDS_PER_SECTOR; i++) begin
                @(posedge clk);
                word = $random(seed);
                cl_of_strobe <= 1'b1;
                cl_of_activate <= (s % 2 == 0) ? 2'b01 : 2'b10;
                cl_of_data <= word;
                write_q.push_back(word);
            end
            // data frame ends right after the last dword
            @(posedge clk);
            cl_of_strobe <= 1'b0;
            cl_of_activate <= 2'b00;
            h2d_data_stb <= 1'b1;
            @(posedge clk);
            h2d_data_stb <= 1'b0;
        end
    endtask

    task automatic read_transfer(input int reg0);
        logic [31:0] word;
        do @(negedge clk); while (!send_data_stb);
        repeat (2) @(posedge clk);
        transport_layer_ready <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            word = $random(seed);
            cl_if_strobe <= 1'b1;
            hd_data_to_host <= word;
            @(negedge clk);
            check_value("hd_write_to_host", 1, hd_write_to_host);
            check_value("cl_if_data", word, cl_if_data);
        end
        @(posedge clk);
        cl_if_strobe <= 1'b0;
        @(negedge clk);
        check_value("hd_write_to_host", 0, hd_write_to_host);
        @(posedge clk);
        check_value("send_reg_stb while transport busy", reg0, reg_count);
        transport_layer_ready <= 1'b1;
    endtask

    task automatic run_row(input int row);
        int errors_before;
        int reg0;
        int dma0;
        int data0;
        logic [7:0] cmd;
        errors_before = error_count;
        cmd = row_cmd[row];
        if (row_srst[row]) begin
            soft_reset();
        end
        @(posedge clk);
        reg0 = reg_count;
        dma0 = dma_count;
        data0 = data_count;
        h2d_command <= cmd;
        h2d_lba <= row_lba[row];
        h2d_sector_count <= row_count[row];
        h2d_cmd_bit <= 1'b1;
        h2d_reg_stb <= 1'b1;
        @(posedge clk);
        h2d_reg_stb <= 1'b0;
        h2d_cmd_bit <= 1'b0;
        @(negedge clk);
        check_value("cl_state", state_after_command(cmd), cl_state);
        if (cmd == `FCL_COMMAND_DMA_WRITE_EX) begin
            write_sectors(row_count[row]);
        end else if (cmd == `FCL_COMMAND_DMA_READ_EX) begin
            read_transfer(reg0);
        end
        wait_ready();
        // status registers follow the completion frame by one cycle
        repeat (2) @(posedge clk);
        check_value("send_reg_stb pulses", 1, reg_count - reg0);
        check_value("send_dma_act_stb pulses",
                    (cmd == `FCL_COMMAND_DMA_WRITE_EX) ? row_count[row] : 0, dma_count - dma0);
        check_value("send_data_stb pulses",
                    (cmd == `FCL_COMMAND_DMA_READ_EX) ? 1 : 0, data_count - data0);
        check_value("pending write dwords", 0, write_q.size());
        @(negedge clk);
        check_value("d2h_lba", row_lba[row], d2h_lba);
        check_value("d2h_sector_count", row_count[row], d2h_sector_count);
        check_value("d2h_status", row_status[row], d2h_status);
        check_value("d2h_error", row_error[row], d2h_error);
        check_value("d2h_interrupt", 1, d2h_interrupt);
        check_value("command_layer_ready", 1, command_layer_ready);
        report_test($sformatf("test %0d, command %02h", row, cmd), errors_before);
    endtask

    initial begin
        hd_data_to_host = 32'd0;
        transport_layer_ready = 1'b1;
        h2d_reg_stb = 1'b0;
        h2d_data_stb = 1'b0;
        h2d_command = 8'h00;
        h2d_cmd_bit = 1'b0;
        h2d_control = 8'h00;
        h2d_lba = 48'd0;
        h2d_sector_count = 16'd0;
        cl_if_strobe = 1'b0;
        cl_of_strobe = 1'b0;
        cl_of_data = 32'd0;
        cl_of_activate = 2'b00;
        do @(negedge clk); while (rst);
        power_up_test();
        for (int row = 0; row < NUM_ROWS; row++) begin
            run_row(row);
        end
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/fcl_pkg.sv
rtl/fcl_sequencer.sv
rtl/fcl_counters.sv
rtl/fcl_data_port.sv
rtl/fcl_register_file.sv
rtl/faux_hd_command_layer.sv
sim/clk_gen.sv
sim/tb_faux_hd_command_layer.sv

/* Bender.yml */
package:
  name: faux_hd_command_layer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fcl_pkg.sv
      - rtl/fcl_sequencer.sv
      - rtl/fcl_counters.sv
      - rtl/fcl_data_port.sv
      - rtl/fcl_register_file.sv
      - rtl/faux_hd_command_layer.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/clk_gen.sv
      - sim/tb_faux_hd_command_layer.sv
